/* Makefile */
TOP = tb_memset
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/10ps -f verilog.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1; cat $(LOG)
	! grep -q "TEST FAILED" $(LOG)
	grep -q "TEST OK" $(LOG)

lint:
	verilator --lint-only -Wall --timing --assert --timescale 1ns/10ps -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

/* host_access.sv */
`timescale 1ns/10ps
`default_nettype none

module host_access
(
	input logic clk,
	input logic reset,
	input logic host_req,
	input logic host_we,
	input logic [memset_pkg::addr_w-1:0] host_addr,
	input logic [memset_pkg::data_w-1:0] host_wdata,
	input logic grant,
	input logic rd_valid,
	input logic [memset_pkg::data_w-1:0] rd_data,
	output logic host_busy,
	output logic host_pend,
	output logic pend_we,
	output logic [memset_pkg::addr_w-1:0] pend_addr,
	output logic [memset_pkg::data_w-1:0] pend_wdata,
	output logic host_rvalid,
	output logic [memset_pkg::data_w-1:0] host_rdata
);

	logic pend_q; // Request waiting for grant.
	logic rd_wait_q; // Granted read waiting for its data.
	logic accept;
	logic rd_done;

	assign accept = host_req && !host_busy;
	assign rd_done = rd_valid && rd_wait_q;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pend_q <= 1'b0;
			rd_wait_q <= 1'b0;
			host_rvalid <= 1'b0;
		end
		else
		begin
			host_rvalid <= 1'b0;
			if (accept)
			begin
				pend_q <= 1'b1;
			end
			else if (grant && pend_q)
			begin
				pend_q <= 1'b0;
				rd_wait_q <= !pend_we; // A write is done at grant.
			end
			if (rd_done)
			begin
				rd_wait_q <= 1'b0;
				host_rvalid <= 1'b1;
			end
		end
	end

	// Request and return data.
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			pend_we <= host_we;
			pend_addr <= host_addr;
			pend_wdata <= host_wdata;
		end
		if (rd_done)
		begin
			host_rdata <= rd_data;
		end
	end

	assign host_pend = pend_q;
	assign host_busy = pend_q || rd_wait_q;

endmodule

`default_nettype wire

/* memory_controller.sv */
`timescale 1ns/10ps
`default_nettype none

module memory_controller
(
	input logic clk,
	input logic reset,
	input logic eng_we,
	input logic [memset_pkg::addr_w-1:0] eng_addr,
	input logic [memset_pkg::data_w-1:0] eng_data,
	input logic host_pend,
	input logic pend_we,
	input logic [memset_pkg::addr_w-1:0] pend_addr,
	input logic [memset_pkg::data_w-1:0] pend_wdata,
	input logic [memset_pkg::data_w-1:0] ram_out,
	output logic grant,
	output logic rd_valid,
	output logic [memset_pkg::data_w-1:0] rd_data,
	output logic [memset_pkg::index_w-1:0] ram_addr,
	output logic ram_we,
	output logic [memset_pkg::data_w-1:0] ram_in
);

	import memset_pkg::*;

	mem_addr_u sel_addr;
	logic host_sel;
	logic sel_we;
	logic [data_w-1:0] sel_data;
	logic in_region;
	logic rd_pend_q; // Host read in flight.
	logic hit_q; // Its region was zero.

	// Engine first, host only in a free cycle.
	always_comb
	begin
		host_sel = host_pend && !eng_we;
		sel_addr.raw = eng_we ? eng_addr : pend_addr;
		sel_data = eng_we ? eng_data : pend_wdata;
		sel_we = eng_we || (host_sel && pend_we);
		in_region = (sel_addr.f.region == '0);
	end

	assign grant = host_sel;

	// Out of region writes are dropped here.
	assign ram_addr = sel_addr.f.index;
	assign ram_we = sel_we && in_region;
	assign ram_in = sel_data;

	// Tag for the read return path.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rd_pend_q <= 1'b0;
			hit_q <= 1'b0;
		end
		else
		begin
			rd_pend_q <= host_sel && !pend_we;
			hit_q <= in_region;
		end
	end

	assign rd_valid = rd_pend_q;
	assign rd_data = hit_q ? ram_out : '0; // Zero outside the RAM.

endmodule

`default_nettype wire

/* memset_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module memset_asserts
(
	input logic clk,
	input logic reset,
	input logic busy,
	input logic finish,
	input logic host_req,
	input logic host_we,
	input logic host_busy,
	input logic host_rvalid
);

	int fail_count = 0;
	logic rd_seen; // Read accepted and not yet returned.

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rd_seen <= 1'b0;
		end
		else if (host_req && !host_busy && !host_we)
		begin
			rd_seen <= 1'b1;
		end
		else if (host_rvalid)
		begin
			rd_seen <= 1'b0;
		end
	end

	finish_pulse: assert property (@(posedge clk) disable iff (reset) finish |=> !finish)
	else
	begin
		$error("finish held high for more than one cycle");
		fail_count++;
	end

	rvalid_pulse: assert property (@(posedge clk) disable iff (reset)
		host_rvalid |=> !host_rvalid)
	else
	begin
		$error("host_rvalid held high for more than one cycle");
		fail_count++;
	end

	// Both busy flags clear straight out of reset.
	reset_idle: assert property (@(posedge clk) $fell(reset) |-> !busy && !host_busy)
	else
	begin
		$error("busy or host_busy high after reset");
		fail_count++;
	end

	busy_after_finish: assert property (@(posedge clk) disable iff (reset) finish |=> !busy)
	else
	begin
		$error("busy still high in the cycle after finish");
		fail_count++;
	end

	rvalid_after_read: assert property (@(posedge clk) disable iff (reset)
		host_rvalid |-> rd_seen)
	else
	begin
		$error("host_rvalid without an accepted host read");
		fail_count++;
	end

endmodule

bind memset_top memset_asserts u_asserts
(
	.clk(clk),
	.reset(reset),
	.busy(busy),
	.finish(finish),
	.host_req(host_req),
	.host_we(host_we),
	.host_busy(host_busy),
	.host_rvalid(host_rvalid)
);

`default_nettype wire

/* memset_engine.sv */
`timescale 1ns/10ps
`default_nettype none

module memset_engine
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic [memset_pkg::addr_w-1:0] m,
	input logic [memset_pkg::data_w-1:0] c,
	input logic [memset_pkg::count_w-1:0] n,
	output logic busy,
	output logic finish,
	output logic [memset_pkg::addr_w-1:0] return_val,
	output logic eng_we,
	output logic [memset_pkg::addr_w-1:0] eng_addr,
	output logic [memset_pkg::data_w-1:0] eng_data
);

	import memset_pkg::*;

	logic [1:0] state_q;
	logic [count_w-1:0] count_q; // Writes still to do.
	mem_addr_u addr_q; // Next write address.
	logic [data_w-1:0] c_q;
	logic [addr_w-1:0] m_q;

	logic start_ok;
	logic zero_len;
	logic last_write;

	// Start is only taken from idle.
	assign start_ok = (state_q == st_idle) && start;
	assign zero_len = (n == '0);
	assign last_write = (state_q == st_run) && (count_q == count_w'(1));

	// FSM.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state_q <= st_idle;
			finish <= 1'b0;
		end
		else
		begin
			finish <= 1'b0; // Single-cycle pulse.
			case (state_q)
				st_idle:
				begin
					if (start_ok)
					begin
						if (zero_len)
						begin
							// Nothing to write so finish comes next cycle.
							state_q <= st_done;
							finish <= 1'b1;
						end
						else
						begin
							state_q <= st_run;
						end
					end
				end
				st_run:
				begin
					if (last_write)
					begin
						state_q <= st_done;
						finish <= 1'b1;
					end
				end
				st_done:
				begin
					state_q <= st_idle;
				end
				default:
				begin
					state_q <= st_idle;
				end
			endcase
		end
	end

	// Operands, address and count.
	always_ff @(posedge clk)
	begin
		if (start_ok)
		begin
			m_q <= m;
			c_q <= c;
			addr_q.raw <= m;
			count_q <= n;
			if (zero_len)
			begin
				return_val <= m;
			end
		end
		else if (state_q == st_run)
		begin
			addr_q.raw <= addr_q.raw + addr_w'(1); // Plain word increment.
			count_q <= count_q - count_w'(1);
			if (last_write)
			begin
				return_val <= m_q;
			end
		end
	end

	// One write per cycle while running.
	assign eng_we = (state_q == st_run);
	assign eng_addr = addr_q.raw;
	assign eng_data = c_q;

	// Busy through the finish cycle.
	assign busy = (state_q != st_idle);

endmodule

`default_nettype wire

/* memset_pkg.sv */
`default_nettype none

package memset_pkg;

	// Address and data widths.
	localparam int addr_w = 32;
	localparam int data_w = 8;
	localparam int count_w = 32; // Fill count n.

	// RAM geometry.
	localparam int index_w = 5;
	localparam int region_w = addr_w - index_w; // 27 bits above the index.
	localparam int ram_depth = 32;

	// Engine FSM encoding.
	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_run = 2'd1;
	localparam logic [1:0] st_done = 2'd2;

	// Split view of an address.
	// A nonzero region lies outside the RAM.
	typedef struct packed {
		logic [region_w-1:0] region;
		logic [index_w-1:0] index;
	} mem_addr_s;

	// One address word seen two ways.
	// The engine steps raw, the controller decodes f.
	typedef union packed {
		logic [addr_w-1:0] raw;
		mem_addr_s f;
	} mem_addr_u;

endpackage

`default_nettype wire

/* memset_top.sv */
`timescale 1ns/10ps
`default_nettype none

module memset_top
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic [memset_pkg::addr_w-1:0] m,
	input logic [memset_pkg::data_w-1:0] c,
	input logic [memset_pkg::count_w-1:0] n,
	input logic host_req,
	input logic host_we,
	input logic [memset_pkg::addr_w-1:0] host_addr,
	input logic [memset_pkg::data_w-1:0] host_wdata,
	output logic busy,
	output logic finish,
	output logic [memset_pkg::addr_w-1:0] return_val,
	output logic host_busy,
	output logic host_rvalid,
	output logic [memset_pkg::data_w-1:0] host_rdata
);

	import memset_pkg::*;

	// Engine request.
	logic eng_we;
	logic [addr_w-1:0] eng_addr;
	logic [data_w-1:0] eng_data;

	// Host request and return.
	logic host_pend;
	logic pend_we;
	logic [addr_w-1:0] pend_addr;
	logic [data_w-1:0] pend_wdata;
	logic grant;
	logic rd_valid;
	logic [data_w-1:0] rd_data;

	// RAM port.
	logic [index_w-1:0] ram_addr;
	logic ram_we;
	logic [data_w-1:0] ram_in;
	logic [data_w-1:0] ram_out;

	memset_engine u_engine (
		.clk(clk),
		.reset(reset),
		.start(start),
		.m(m),
		.c(c),
		.n(n),
		.busy(busy),
		.finish(finish),
		.return_val(return_val),
		.eng_we(eng_we),
		.eng_addr(eng_addr),
		.eng_data(eng_data)
	);

	host_access u_host (
		.clk(clk),
		.reset(reset),
		.host_req(host_req),
		.host_we(host_we),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.grant(grant),
		.rd_valid(rd_valid),
		.rd_data(rd_data),
		.host_busy(host_busy),
		.host_pend(host_pend),
		.pend_we(pend_we),
		.pend_addr(pend_addr),
		.pend_wdata(pend_wdata),
		.host_rvalid(host_rvalid),
		.host_rdata(host_rdata)
	);

	memory_controller u_ctrl (
		.clk(clk),
		.reset(reset),
		.eng_we(eng_we),
		.eng_addr(eng_addr),
		.eng_data(eng_data),
		.host_pend(host_pend),
		.pend_we(pend_we),
		.pend_addr(pend_addr),
		.pend_wdata(pend_wdata),
		.ram_out(ram_out),
		.grant(grant),
		.rd_valid(rd_valid),
		.rd_data(rd_data),
		.ram_addr(ram_addr),
		.ram_we(ram_we),
		.ram_in(ram_in)
	);

	single_port_ram u_ram (
		.clk(clk),
		.ram_addr(ram_addr),
		.ram_we(ram_we),
		.ram_in(ram_in),
		.ram_out(ram_out)
	);

endmodule

`default_nettype wire

/* single_port_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module single_port_ram
(
	input logic clk,
	input logic [memset_pkg::index_w-1:0] ram_addr,
	input logic ram_we,
	input logic [memset_pkg::data_w-1:0] ram_in,
	output logic [memset_pkg::data_w-1:0] ram_out
);

	import memset_pkg::*;

	// Byte storage.
	logic [data_w-1:0] mem [0:ram_depth-1];

	// Write on the edge.
	always_ff @(posedge clk)
	begin
		if (ram_we)
		begin
			mem[ram_addr] <= ram_in;
		end
	end

	// Registered read returns the old word on a same-cycle write.
	always_ff @(posedge clk)
	begin
		ram_out <= mem[ram_addr];
	end

endmodule

`default_nettype wire

/* tb_memset.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_memset;

	import memset_pkg::*;

	localparam int rd_len = 4; // Idle read from drive edge to host_rvalid.
	localparam int wr_len = 3; // Idle write from drive edge to host_busy low.
	localparam int sweep_len = ram_depth * rd_len;
	localparam int test_len = ram_depth * wr_len
		+ 34 + sweep_len
		+ 2 + sweep_len
		+ wr_len + rd_len
		+ 60 + wr_len + 2 * rd_len + sweep_len
		+ wr_len + rd_len + 10 + sweep_len
		+ 6 * 42 + sweep_len
		+ 10;
	localparam int max_cycles = 2 * test_len + 200;

	logic clk;
	logic reset;
	logic start;
	logic [addr_w-1:0] m;
	logic [data_w-1:0] c;
	logic [count_w-1:0] n;
	logic host_req;
	logic host_we;
	logic [addr_w-1:0] host_addr;
	logic [data_w-1:0] host_wdata;
	logic busy;
	logic finish;
	logic [addr_w-1:0] return_val;
	logic host_busy;
	logic host_rvalid;
	logic [data_w-1:0] host_rdata;

	// Reference copy of the RAM and the values the checks expect.
	logic [data_w-1:0] ref_mem [0:ram_depth-1];
	logic [data_w-1:0] exp_rdata;
	logic [addr_w-1:0] m_lat;
	logic [count_w-1:0] n_lat;
	logic [31:0] since_start; // Cycles since the last accepted start.
	logic rd_open; // Host read accepted and its data not yet back.
	logic [31:0] rng;
	int error_count = 0;
	int errors_before = 0;
	int cycle_count = 0;

	memset_top u_memset_top (.*);

	always #4 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Fill rule where writes beyond region zero are lost.
	task automatic apply_fill(input logic [31:0] fm, input logic [7:0] fc,
		input logic [31:0] fn);
		logic [31:0] k;
		logic [31:0] a;
		for (k = 0; k < fn; k++)
		begin
			a = fm + k;
			if (a[addr_w-1:index_w] == '0)
			begin
				ref_mem[a[index_w-1:0]] = fc;
			end
		end
	endtask

	always @(posedge clk)
	begin
		if (reset)
		begin
			since_start <= '0;
			rd_open <= 1'b0;
			exp_rdata <= '0;
			m_lat <= '0;
			n_lat <= '0;
		end
		else
		begin
			if (start && !busy)
			begin
				m_lat <= m;
				n_lat <= n;
				since_start <= 32'd1;
				apply_fill(m, c, n);
			end
			else
			begin
				since_start <= since_start + 32'd1;
			end
			if (host_req && !host_busy)
			begin
				if (host_we && host_addr[addr_w-1:index_w] == '0)
				begin
					ref_mem[host_addr[index_w-1:0]] = host_wdata;
				end
				else if (!host_we)
				begin
					rd_open <= 1'b1;
					exp_rdata <= (host_addr[addr_w-1:index_w] == '0) ?
						ref_mem[host_addr[index_w-1:0]] : '0;
				end
			end
			if (host_rvalid)
			begin
				rd_open <= 1'b0;
			end
		end
	end

	read_data_check: assert property (@(posedge clk) disable iff (reset)
		host_rvalid |-> host_rdata == exp_rdata)
	else
	begin
		$display("** Error at %0t: host_rdata = %h, expected %h", $time,
			$sampled(host_rdata), $sampled(exp_rdata));
		error_count++;
	end

	return_check: assert property (@(posedge clk) disable iff (reset)
		finish |-> return_val == m_lat)
	else
	begin
		$display("** Error at %0t: return_val = %h, expected %h", $time,
			$sampled(return_val), $sampled(m_lat));
		error_count++;
	end

	finish_time_check: assert property (@(posedge clk) disable iff (reset)
		finish |-> since_start == n_lat + 32'd1)
	else
	begin
		$display("** Error at %0t: finish after %0d cycles, expected %0d", $time,
			$sampled(since_start), $sampled(n_lat) + 32'd1);
		error_count++;
	end

	read_busy_check: assert property (@(posedge clk) disable iff (reset)
		rd_open && !host_rvalid |-> host_busy)
	else
	begin
		$display("At %0t host_busy dropped before the read data came back.", $time);
		error_count++;
	end

	task automatic run_fill(input logic [31:0] fm, input logic [7:0] fc,
		input logic [31:0] fn);
		start <= 1'b1;
		m <= fm;
		c <= fc;
		n <= fn;
		@(posedge clk);
		start <= 1'b0;
		do
		begin
			@(posedge clk);
		end
		while (!finish);
	endtask

	task automatic host_write(input logic [31:0] a, input logic [7:0] d, output int lat);
		host_req <= 1'b1;
		host_we <= 1'b1;
		host_addr <= a;
		host_wdata <= d;
		@(posedge clk);
		host_req <= 1'b0;
		lat = 1;
		do
		begin
			@(posedge clk);
			lat++;
		end
		while (host_busy);
	endtask

	task automatic host_read(input logic [31:0] a, output int lat);
		host_req <= 1'b1;
		host_we <= 1'b0;
		host_addr <= a;
		@(posedge clk);
		host_req <= 1'b0;
		lat = 1;
		while (!host_rvalid)
		begin
			@(posedge clk);
			lat++;
		end
	endtask

	task automatic read_all();
		int lat;
		for (int i = 0; i < ram_depth; i++)
		begin
			host_read(32'(i), lat);
		end
	endtask

	task automatic end_test(input string name);
		int total;
		@(posedge clk);
		total = error_count + u_memset_top.u_asserts.fail_count;
		$display("%s: %0d errors", name, total - errors_before);
		errors_before = total;
	endtask

	initial
	begin
		while (cycle_count < max_cycles)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, the DUT stopped answering.", cycle_count);
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		int lat;
		int total;
		logic [31:0] fm;
		logic [31:0] fn;
		clk = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		m = '0;
		c = '0;
		n = '0;
		host_req = 1'b0;
		host_we = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		rng = 32'hd9d468b6;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);

		// Every entry gets a known value first.
		for (int i = 0; i < ram_depth; i++)
		begin
			rng = lcg_next(rng);
			host_write(32'(i), rng[23:16], lat);
		end
		end_test("Preload");

		rng = lcg_next(rng);
		fm = {27'd0, rng[28:24]};
		rng = lcg_next(rng);
		fn = 32'd1 + (rng % (32'd32 - fm));
		run_fill(fm, rng[15:8], fn);
		read_all();
		end_test("Test 1 random fill");

		rng = lcg_next(rng);
		run_fill({27'd0, rng[20:16]}, 8'h5a, 32'd0);
		read_all();
		end_test("Test 2 zero count");

		rng = lcg_next(rng);
		host_write({27'd0, rng[4:0]}, rng[31:24], lat);
		host_read({27'd0, rng[4:0]}, lat);
		assert (lat == rd_len)
		else
		begin
			$display("** Error at %0t: read latency = %0d, expected %0d", $time, lat, rd_len);
			error_count++;
		end
		end_test("Test 3 host write and read");

		// Host ops held off by a long fill.
		rng = lcg_next(rng);
		fork
			run_fill(32'd4, rng[7:0], 32'd24);
			begin
				repeat (2) @(posedge clk);
				host_write(32'd10, rng[15:8], lat);
			end
		join
		assert (lat > wr_len)
		else
		begin
			$display("Host write during the fill was not held back.");
			error_count++;
		end
		host_read(32'd10, lat);
		rng = lcg_next(rng);
		fork
			run_fill(32'd0, rng[23:16], 32'd28);
			begin
				repeat (3) @(posedge clk);
				host_read(32'd20, lat);
			end
		join
		assert (lat > rd_len)
		else
		begin
			$display("Host read during the fill was not held back.");
			error_count++;
		end
		read_all();
		end_test("Test 4 host during fill");

		host_write(32'h0000_0123, 8'ha5, lat); // Region 9, index 3.
		host_read(32'h0000_0123, lat);
		run_fill(32'd28, 8'h3c, 32'd8); // Last four writes leave the RAM.
		read_all();
		end_test("Test 5 out of region");

		for (int k = 0; k < 6; k++)
		begin
			rng = lcg_next(rng);
			run_fill({26'd0, rng[29:24]}, rng[7:0], {26'd0, rng[13:8]} % 32'd41);
		end
		read_all();
		end_test("Test 6 back-to-back fills");

		repeat (2) @(posedge clk);
		total = error_count + u_memset_top.u_asserts.fail_count;
		$display("Summary: 7 tests, %0d errors", total);
		if (total == 0)
		begin
			$display("TEST OK");
		end
		else
		begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
memset_pkg.sv
single_port_ram.sv
memset_engine.sv
host_access.sv
memory_controller.sv
memset_top.sv
memset_asserts.sv
tb_memset.sv
